// ==== design/roce_pkg.sv ====
package roce_pkg;

  localparam int data_bytes       = 8;
  localparam int fifo_depth       = 16;
  localparam int fifo_ptr_w       = $clog2(fifo_depth);
  localparam int msg_per_transfer = 2;

  typedef logic [63:0] data_t;
  typedef logic [7:0]  keep_t;
  typedef logic [31:0] len_t;
  typedef logic [23:0] psn_t;
  typedef logic [63:0] vaddr_t;
  typedef logic [12:0] pmtu_t;
  typedef logic [15:0] port_t;

  // RoCEv2 well known destination port
  localparam port_t roce_udp_port = 16'h12B7;

  typedef enum logic [1:0] {
    qp_idle,
    qp_run,
    qp_wait_done
  } qp_state_t;

  // low aligned byte enables, a count of 0 means a full beat
  function automatic keep_t count2keep(input logic [3:0] count);
    keep_t keep;
    if (count == 4'd0 || count >= 4'd8) begin
      keep = '1;
    end else begin
      keep = keep_t'((9'd1 << count) - 9'd1);
    end
    return keep;
  endfunction

endpackage

// ==== design/roce_payload_gen.sv ====
`timescale 1ns/1ps

module roce_payload_gen import roce_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  msg_start,
  input  len_t  msg_length,
  output data_t gen_data,
  output keep_t gen_keep,
  output logic  gen_valid,
  input  logic  gen_ready,
  output logic  gen_last,
  output logic  msg_done
);

  len_t offset;
  len_t len_reg;
  logic beat_fire;

  // byte offset of the beat on offer
  always_ff @(posedge clk) begin
    if (rst) begin
      offset  <= '0;
      len_reg <= '0;
    end else if (msg_start) begin
      offset  <= '0;
      len_reg <= msg_length;
    end else if (beat_fire) begin
      offset <= offset + len_t'(data_bytes);
    end
  end

  assign gen_valid = offset < len_reg;
  assign beat_fire = gen_valid && gen_ready;

  // 33 bit compare so lengths near the top of the range still terminate
  assign gen_last = ({1'b0, offset} + 33'(data_bytes)) >= {1'b0, len_reg};

  assign gen_data = {~offset, offset};

  // only the tail beat may be partial
  assign gen_keep = gen_last ? count2keep({1'b0, len_reg[2:0]}) : '1;

  assign msg_done = beat_fire && gen_last;

  a_data_hold: assert property (
    @(posedge clk) disable iff (rst)
    gen_valid && !gen_ready |=> gen_valid && $stable(gen_data) && $stable(gen_keep)
  ) else $error("payload beat changed while stalled");

endmodule

// ==== design/roce_payload_fifo.sv ====
`timescale 1ns/1ps

module roce_payload_fifo import roce_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  data_t s_data,
  input  keep_t s_keep,
  input  logic  s_valid,
  output logic  s_ready,
  input  logic  s_last,
  output data_t m_data,
  output keep_t m_keep,
  output logic  m_valid,
  input  logic  m_ready,
  output logic  m_last
);

  data_t mem_data [fifo_depth];
  keep_t mem_keep [fifo_depth];
  logic  mem_last [fifo_depth];

  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w:0]   count;
  logic                  wr_en;
  logic                  rd_en;

  assign s_ready = count != (fifo_ptr_w + 1)'(fifo_depth);
  assign m_valid = count != '0;
  assign wr_en   = s_valid && s_ready;
  assign rd_en   = m_valid && m_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_data[wr_ptr] <= s_data;
      mem_keep[wr_ptr] <= s_keep;
      mem_last[wr_ptr] <= s_last;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + fifo_ptr_w'(1);
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + fifo_ptr_w'(1);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + (fifo_ptr_w + 1)'(1);
        2'b01:   count <= count - (fifo_ptr_w + 1)'(1);
        default: count <= count;
      endcase
    end
  end

  // head entry shows directly, first word fall through
  assign m_data = mem_data[rd_ptr];
  assign m_keep = mem_keep[rd_ptr];
  assign m_last = mem_last[rd_ptr];

  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst) count <= (fifo_ptr_w + 1)'(fifo_depth)
  ) else $error("write into full payload FIFO");

  a_no_underflow: assert property (
    @(posedge clk) disable iff (rst) count == '0 |=> count <= (fifo_ptr_w + 1)'(1)
  ) else $error("read from empty payload FIFO");

endmodule

// ==== design/roce_qp_tx_state.sv ====
`timescale 1ns/1ps

module roce_qp_tx_state import roce_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   start,
  input  len_t   init_length,
  input  psn_t   init_psn,
  input  vaddr_t init_addr,
  input  pmtu_t  pmtu,
  output logic   msg_start,
  output len_t   msg_length,
  input  logic   msg_done,
  output logic   desc_valid,
  input  logic   desc_ready,
  output psn_t   desc_psn,
  output vaddr_t desc_addr,
  output len_t   desc_length,
  output logic   busy
);

  qp_state_t state;
  logic [7:0] msg_cnt;
  logic       desc_seen;
  logic       done_seen;
  logic       desc_fire;
  logic       msg_complete;

  len_t   len_reg;
  psn_t   psn_reg;
  vaddr_t addr_base;
  vaddr_t addr_off;
  pmtu_t  pmtu_reg;
  logic [3:0] pmtu_shift;
  len_t   pmtu_mask;
  psn_t   psn_step;

  assign desc_fire    = desc_valid && desc_ready;
  assign msg_complete = (desc_seen || desc_fire) && (done_seen || msg_done);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= qp_idle;
      msg_cnt    <= '0;
      desc_valid <= 1'b0;
      desc_seen  <= 1'b0;
      done_seen  <= 1'b0;
    end else begin
      if (desc_fire) begin
        desc_valid <= 1'b0;
        desc_seen  <= 1'b1;
      end
      if (msg_done) begin
        done_seen <= 1'b1;
      end
      case (state)
        qp_idle: begin
          if (start) begin
            msg_cnt    <= '0;
            desc_valid <= 1'b1;
            desc_seen  <= 1'b0;
            done_seen  <= 1'b0;
            state      <= qp_run;
          end
        end
        qp_run: state <= qp_wait_done;
        qp_wait_done: begin
          // both payload and descriptor of this message are through
          if (msg_complete) begin
            desc_seen <= 1'b0;
            done_seen <= 1'b0;
            if (msg_cnt == 8'(msg_per_transfer - 1)) begin
              state <= qp_idle;
            end else begin
              msg_cnt    <= msg_cnt + 8'd1;
              desc_valid <= 1'b1;
              state      <= qp_run;
            end
          end
        end
        default: state <= qp_idle;
      endcase
    end
  end

  always_comb begin
    case (pmtu_reg)
      13'd512:  pmtu_shift = 4'd9;
      13'd1024: pmtu_shift = 4'd10;
      13'd2048: pmtu_shift = 4'd11;
      13'd4096: pmtu_shift = 4'd12;
      default:  pmtu_shift = 4'd8;
    endcase
  end

  // packets per message, rounded up
  assign pmtu_mask = (len_t'(1) << pmtu_shift) - len_t'(1);
  assign psn_step  = psn_t'(len_reg >> pmtu_shift) + psn_t'(|(len_reg & pmtu_mask));

  always_ff @(posedge clk) begin
    if (state == qp_idle && start) begin
      len_reg   <= init_length;
      psn_reg   <= init_psn;
      addr_base <= init_addr;
      addr_off  <= '0;
      pmtu_reg  <= pmtu;
    end else if (desc_fire) begin
      psn_reg  <= psn_reg + psn_step;
      addr_off <= addr_off + vaddr_t'(len_reg);
    end
  end

  assign msg_start   = state == qp_run;
  assign msg_length  = len_reg;
  assign desc_psn    = psn_reg;
  assign desc_addr   = addr_base + addr_off;
  assign desc_length = len_reg;
  assign busy        = state != qp_idle;

  a_pmtu_legal: assert property (
    @(posedge clk) disable iff (rst)
    start |-> pmtu inside {13'd256, 13'd512, 13'd1024, 13'd2048, 13'd4096}
  ) else $error("illegal path MTU %0d", pmtu);

endmodule

// ==== design/udp_rx_steer.sv ====
`timescale 1ns/1ps

module udp_rx_steer import roce_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  s_hdr_valid,
  output logic  s_hdr_ready,
  input  port_t s_dest_port,
  input  data_t s_data,
  input  keep_t s_keep,
  input  logic  s_valid,
  output logic  s_ready,
  input  logic  s_last,
  output logic  roce_hdr_valid,
  input  logic  roce_hdr_ready,
  output logic  other_hdr_valid,
  input  logic  other_hdr_ready,
  output data_t roce_data,
  output keep_t roce_keep,
  output logic  roce_valid,
  input  logic  roce_ready,
  output logic  roce_last,
  output data_t other_data,
  output keep_t other_keep,
  output logic  other_valid,
  input  logic  other_ready,
  output logic  other_last
);

  logic port_is_roce;
  logic in_frame;
  logic frame_roce;
  logic route_roce;
  logic beat_fire;

  assign port_is_roce = s_dest_port == roce_udp_port;

  // headers follow the port directly
  assign roce_hdr_valid  = s_hdr_valid && port_is_roce;
  assign other_hdr_valid = s_hdr_valid && !port_is_roce;
  assign s_hdr_ready     = port_is_roce ? roce_hdr_ready : other_hdr_ready;

  // first beat routes by port, later beats by the latched choice
  assign route_roce = in_frame ? frame_roce : port_is_roce;
  assign beat_fire  = s_valid && s_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_frame   <= 1'b0;
      frame_roce <= 1'b0;
    end else if (beat_fire) begin
      in_frame   <= !s_last;
      frame_roce <= route_roce;
    end
  end

  assign s_ready = route_roce ? roce_ready : other_ready;

  assign roce_data  = s_data;
  assign roce_keep  = s_keep;
  assign roce_last  = s_last;
  assign roce_valid = s_valid && route_roce;

  assign other_data  = s_data;
  assign other_keep  = s_keep;
  assign other_last  = s_last;
  assign other_valid = s_valid && !route_roce;

  // a frame stays on the output its first beat took
  a_frame_held: assert property (
    @(posedge clk) disable iff (rst) beat_fire && !s_last |=> route_roce == $past(route_roce)
  ) else $error("frame split between outputs");

endmodule

// ==== design/roce_tx_stream.sv ====
`timescale 1ns/1ps

module roce_tx_stream import roce_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   start,
  input  len_t   init_length,
  input  psn_t   init_psn,
  input  vaddr_t init_addr,
  input  pmtu_t  pmtu,
  output logic   desc_valid,
  input  logic   desc_ready,
  output psn_t   desc_psn,
  output vaddr_t desc_addr,
  output len_t   desc_length,
  output data_t  m_data,
  output keep_t  m_keep,
  output logic   m_valid,
  input  logic   m_ready,
  output logic   m_last,
  output logic   busy,
  input  logic   rx_s_hdr_valid,
  output logic   rx_s_hdr_ready,
  input  port_t  rx_s_dest_port,
  input  data_t  rx_s_data,
  input  keep_t  rx_s_keep,
  input  logic   rx_s_valid,
  output logic   rx_s_ready,
  input  logic   rx_s_last,
  output logic   rx_roce_hdr_valid,
  input  logic   rx_roce_hdr_ready,
  output logic   rx_other_hdr_valid,
  input  logic   rx_other_hdr_ready,
  output data_t  rx_roce_data,
  output keep_t  rx_roce_keep,
  output logic   rx_roce_valid,
  input  logic   rx_roce_ready,
  output logic   rx_roce_last,
  output data_t  rx_other_data,
  output keep_t  rx_other_keep,
  output logic   rx_other_valid,
  input  logic   rx_other_ready,
  output logic   rx_other_last
);

  logic  msg_start;
  len_t  msg_length;
  logic  msg_done;
  data_t gen_data;
  keep_t gen_keep;
  logic  gen_valid;
  logic  gen_ready;
  logic  gen_last;

  roce_qp_tx_state qp_tx_state_i (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .init_length(init_length),
    .init_psn   (init_psn),
    .init_addr  (init_addr),
    .pmtu       (pmtu),
    .msg_start  (msg_start),
    .msg_length (msg_length),
    .msg_done   (msg_done),
    .desc_valid (desc_valid),
    .desc_ready (desc_ready),
    .desc_psn   (desc_psn),
    .desc_addr  (desc_addr),
    .desc_length(desc_length),
    .busy       (busy)
  );

  roce_payload_gen payload_gen_i (
    .clk       (clk),
    .rst       (rst),
    .msg_start (msg_start),
    .msg_length(msg_length),
    .gen_data  (gen_data),
    .gen_keep  (gen_keep),
    .gen_valid (gen_valid),
    .gen_ready (gen_ready),
    .gen_last  (gen_last),
    .msg_done  (msg_done)
  );

  roce_payload_fifo payload_fifo_i (
    .clk    (clk),
    .rst    (rst),
    .s_data (gen_data),
    .s_keep (gen_keep),
    .s_valid(gen_valid),
    .s_ready(gen_ready),
    .s_last (gen_last),
    .m_data (m_data),
    .m_keep (m_keep),
    .m_valid(m_valid),
    .m_ready(m_ready),
    .m_last (m_last)
  );

  // receive side steering, independent of the transmit chain
  udp_rx_steer rx_steer_i (
    .clk            (clk),
    .rst            (rst),
    .s_hdr_valid    (rx_s_hdr_valid),
    .s_hdr_ready    (rx_s_hdr_ready),
    .s_dest_port    (rx_s_dest_port),
    .s_data         (rx_s_data),
    .s_keep         (rx_s_keep),
    .s_valid        (rx_s_valid),
    .s_ready        (rx_s_ready),
    .s_last         (rx_s_last),
    .roce_hdr_valid (rx_roce_hdr_valid),
    .roce_hdr_ready (rx_roce_hdr_ready),
    .other_hdr_valid(rx_other_hdr_valid),
    .other_hdr_ready(rx_other_hdr_ready),
    .roce_data      (rx_roce_data),
    .roce_keep      (rx_roce_keep),
    .roce_valid     (rx_roce_valid),
    .roce_ready     (rx_roce_ready),
    .roce_last      (rx_roce_last),
    .other_data     (rx_other_data),
    .other_keep     (rx_other_keep),
    .other_valid    (rx_other_valid),
    .other_ready    (rx_other_ready),
    .other_last     (rx_other_last)
  );

endmodule

// ==== tb/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
  output logic clk
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

endmodule

// ==== tb/roce_tx_stream_tb.sv ====
`timescale 1ns/1ps

module roce_tx_stream_tb import roce_pkg::*; ();

  localparam int          wait_limit = 20000;
  localparam int          rx_frames  = 24;
  localparam logic [31:0] lfsr_seed  = 32'h6ca2_fac1;

  logic   clk;
  logic   rst;
  logic   start;
  len_t   init_length;
  psn_t   init_psn;
  vaddr_t init_addr;
  pmtu_t  pmtu;
  logic   desc_valid, desc_ready;
  psn_t   desc_psn;
  vaddr_t desc_addr;
  len_t   desc_length;
  data_t  m_data;
  keep_t  m_keep;
  logic   m_valid, m_ready, m_last, busy;
  logic   rx_s_hdr_valid, rx_s_hdr_ready;
  port_t  rx_s_dest_port;
  data_t  rx_s_data, rx_roce_data, rx_other_data;
  keep_t  rx_s_keep, rx_roce_keep, rx_other_keep;
  logic   rx_s_valid, rx_s_ready, rx_s_last;
  logic   rx_roce_hdr_valid, rx_roce_hdr_ready, rx_other_hdr_valid, rx_other_hdr_ready;
  logic   rx_roce_valid, rx_roce_ready, rx_roce_last;
  logic   rx_other_valid, rx_other_ready, rx_other_last;

  logic [31:0]  lfsr_state;
  logic [72:0]  beat_q [$];
  logic [119:0] desc_q [$];
  logic [72:0]  roce_q [$];
  logic [72:0]  other_q [$];
  string        test_name;
  int           errors, errors_at_start, tests_run, tests_failed;
  int           last_cnt, desc_cnt;
  logic         timed_out, rand_ready;
  logic         rx_in_fire, rx_hdr_fire;
  logic         rx_port_roce;

  clk_gen clk_gen_i (.clk(clk));

  roce_tx_stream roce_tx_stream_i (.*);

  assign rx_port_roce = rx_s_dest_port == 16'd4791;

  // taps 32, 22, 2, 1
  function logic next_rand_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_rand_bit()};
    end
    return v;
  endfunction

  function keep_t tail_keep(input len_t len);
    int rem;
    rem = int'(len[2:0]);
    if (rem == 0) begin
      return 8'hFF;
    end
    return 8'hFF >> (8 - rem);
  endfunction

  // expected beats and descriptors of one start pulse
  task automatic push_transfer(input len_t len, input psn_t psn, input vaddr_t addr,
                               input pmtu_t mtu);
    len_t   off;
    psn_t   p;
    vaddr_t a;
    logic   last;
    keep_t  k;
    p = psn;
    a = addr;
    for (int m = 0; m < msg_per_transfer; m++) begin
      off = '0;
      while (off < len) begin
        last = (64'(off) + 64'd8) >= 64'(len);
        k = last ? tail_keep(len) : 8'hFF;
        beat_q.push_back({last, k, ~off, off});
        off = off + 32'd8;
      end
      desc_q.push_back({p, a, len});
      // packets per message, rounded up
      p = p + psn_t'((len + 32'(mtu) - 32'd1) / 32'(mtu));
      a = a + 64'(len);
    end
  endtask

  always @(posedge clk) begin
    if (!rst && m_valid && m_ready) begin
      if (beat_q.size() == 0) begin
        $display("%s: payload beat arrived with none expected", test_name);
        errors++;
      end else begin
        assert ({m_last, m_keep, m_data} == beat_q[0]) else begin
          $display("Error %s: beat expected %h actual %h", test_name, beat_q[0],
                   {m_last, m_keep, m_data});
          errors++;
        end
        void'(beat_q.pop_front());
      end
      if (m_last) begin
        last_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && desc_valid && desc_ready) begin
      desc_cnt++;
      if (desc_q.size() == 0) begin
        $display("%s: descriptor arrived with none expected", test_name);
        errors++;
      end else begin
        assert ({desc_psn, desc_addr, desc_length} == desc_q[0]) else begin
          $display("Error %s: descriptor expected %h actual %h", test_name, desc_q[0],
                   {desc_psn, desc_addr, desc_length});
          errors++;
        end
        void'(desc_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    rx_in_fire  <= rx_s_valid && rx_s_ready;
    rx_hdr_fire <= rx_s_hdr_valid && rx_s_hdr_ready;
    if (!rst && rx_s_hdr_valid) begin
      assert ({rx_roce_hdr_valid, rx_other_hdr_valid} == {rx_port_roce, !rx_port_roce})
      else begin
        $display("Error %s: header valids expected %b actual %b", test_name,
                 {rx_port_roce, !rx_port_roce}, {rx_roce_hdr_valid, rx_other_hdr_valid});
        errors++;
      end
      // header ready comes from the output the port selects
      assert (rx_s_hdr_ready == (rx_port_roce ? rx_roce_hdr_ready : rx_other_hdr_ready))
      else begin
        $display("Error %s: header ready expected %b actual %b", test_name,
                 rx_port_roce ? rx_roce_hdr_ready : rx_other_hdr_ready, rx_s_hdr_ready);
        errors++;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && rx_roce_valid && rx_roce_ready) begin
      if (roce_q.size() == 0) begin
        $display("%s: beat on the RoCE output with none expected", test_name);
        errors++;
      end else begin
        assert ({rx_roce_last, rx_roce_keep, rx_roce_data} == roce_q[0]) else begin
          $display("Error %s: RoCE beat expected %h actual %h", test_name, roce_q[0],
                   {rx_roce_last, rx_roce_keep, rx_roce_data});
          errors++;
        end
        void'(roce_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && rx_other_valid && rx_other_ready) begin
      if (other_q.size() == 0) begin
        $display("%s: beat on the other output with none expected", test_name);
        errors++;
      end else begin
        assert ({rx_other_last, rx_other_keep, rx_other_data} == other_q[0]) else begin
          $display("Error %s: other beat expected %h actual %h", test_name, other_q[0],
                   {rx_other_last, rx_other_keep, rx_other_data});
          errors++;
        end
        void'(other_q.pop_front());
      end
    end
  end

  a_m_stable: assert property (
    @(posedge clk) disable iff (rst)
    m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_keep) && $stable(m_last)
  ) else begin
    $display("%s: payload output changed while stalled", test_name);
    errors++;
  end

  a_rx_one_output: assert property (
    @(posedge clk) disable iff (rst) !(rx_roce_valid && rx_other_valid)
  ) else begin
    $display("%s: RX beat offered on both outputs", test_name);
    errors++;
  end

  task automatic begin_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %s done, no errors", test_name);
    end else begin
      tests_failed++;
      $display("test %s done, %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("%s: timed out waiting for %s", test_name, what);
    timed_out = 1'b1;
    errors++;
  endtask

  // called on a falling edge, returns on the next one
  task automatic run_transfer(input len_t len, input psn_t psn, input vaddr_t addr,
                              input pmtu_t mtu);
    push_transfer(len, psn, addr, mtu);
    init_length = len;
    init_psn    = psn;
    init_addr   = addr;
    pmtu        = mtu;
    start       = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_tx_idle();
    int n;
    n = 0;
    while ((busy || beat_q.size() != 0 || desc_q.size() != 0) && n < wait_limit) begin
      if (rand_ready) begin
        m_ready    = next_rand_bit();
        desc_ready = next_rand_bit();
      end
      @(negedge clk);
      n++;
    end
    if (busy || beat_q.size() != 0 || desc_q.size() != 0) begin
      report_timeout("the transmit side to finish");
    end
    m_ready    = 1'b1;
    desc_ready = 1'b1;
  endtask

  task automatic drive_rx_readies();
    rx_roce_ready      = next_rand_bit();
    rx_other_ready     = next_rand_bit();
    rx_roce_hdr_ready  = next_rand_bit();
    rx_other_hdr_ready = next_rand_bit();
  endtask

  task automatic send_rx_header();
    int n;
    n = 0;
    rx_s_hdr_valid = 1'b1;
    do begin
      drive_rx_readies();
      @(negedge clk);
      n++;
    end while (!rx_hdr_fire && n < wait_limit);
    rx_s_hdr_valid = 1'b0;
    if (!rx_hdr_fire) begin
      report_timeout("an RX header handshake");
    end
  endtask

  task automatic send_rx_beat(input data_t d, input keep_t k, input logic last);
    int n;
    n = 0;
    rx_s_data  = d;
    rx_s_keep  = k;
    rx_s_last  = last;
    rx_s_valid = 1'b1;
    do begin
      drive_rx_readies();
      @(negedge clk);
      n++;
    end while (!rx_in_fire && n < wait_limit);
    rx_s_valid = 1'b0;
    if (!rx_in_fire) begin
      report_timeout("an RX beat handshake");
    end
  endtask

  task automatic verify_reset();
    begin_test("reset");
    assert (!busy && !desc_valid && !m_valid && !rx_roce_valid && !rx_other_valid
            && !rx_roce_hdr_valid && !rx_other_hdr_valid) else begin
      $display("%s: busy or an output valid was high after reset", test_name);
      errors++;
    end
    end_test();
  endtask

  task automatic payload_pattern();
    begin_test("payload");
    run_transfer(32'd20, 24'd0, 64'h0, 13'd256);
    wait_tx_idle();
    run_transfer(32'd24, 24'd10, 64'h40, 13'd256);
    wait_tx_idle();
    end_test();
  endtask

  task automatic descriptor_sequence();
    begin_test("descriptor");
    run_transfer(32'd1300, 24'd100, 64'h0000_1000_0000_0000, 13'd256);
    wait_tx_idle();
    // step of 2 across the 24 bit wrap
    run_transfer(32'd1024, 24'hFF_FFFF, 64'h0000_2000_0000_0000, 13'd512);
    wait_tx_idle();
    end_test();
  endtask

  task automatic message_count();
    int lasts_before;
    int descs_before;
    begin_test("msg_count");
    lasts_before = last_cnt;
    descs_before = desc_cnt;
    run_transfer(32'd64, 24'd7, 64'h8000, 13'd1024);
    if (!busy) begin
      $display("%s: busy stayed low after start", test_name);
      errors++;
    end
    // second start lands while busy and must be ignored
    init_length = 32'd200;
    start       = 1'b1;
    @(negedge clk);
    start = 1'b0;
    wait_tx_idle();
    assert (last_cnt - lasts_before == msg_per_transfer) else begin
      $display("Error %s: tlast beats expected %0d actual %0d", test_name,
               msg_per_transfer, last_cnt - lasts_before);
      errors++;
    end
    assert (desc_cnt - descs_before == msg_per_transfer) else begin
      $display("Error %s: descriptors expected %0d actual %0d", test_name,
               msg_per_transfer, desc_cnt - descs_before);
      errors++;
    end
    end_test();
  endtask

  task automatic back_pressure();
    begin_test("back_pressure");
    rand_ready = 1'b1;
    for (int t = 0; t < 4 && !timed_out; t++) begin
      run_transfer(len_t'(32'd1 + rand_bits(9)), psn_t'(rand_bits(24)),
                   {rand_bits(32), rand_bits(32)}, pmtu_t'(13'd256 << rand_bits(2)));
      wait_tx_idle();
    end
    rand_ready = 1'b0;
    end_test();
  endtask

  task automatic rx_steering();
    port_t port;
    int    nbeats;
    data_t d;
    keep_t k;
    logic  last;
    begin_test("rx_steer");
    for (int f = 0; f < rx_frames && !timed_out; f++) begin
      port = next_rand_bit() ? 16'd4791 : port_t'(32'd1024 + rand_bits(10));
      nbeats = 1 + int'(rand_bits(2));
      rx_s_dest_port = port;
      send_rx_header();
      for (int b = 0; b < nbeats && !timed_out; b++) begin
        last = b == nbeats - 1;
        k = last ? (keep_t'(rand_bits(8)) | 8'h01) : 8'hFF;
        d = {rand_bits(32), 16'(f), 16'(b)};
        if (port == 16'd4791) begin
          roce_q.push_back({last, k, d});
        end else begin
          other_q.push_back({last, k, d});
        end
        send_rx_beat(d, k, last);
        // later beats must follow the frame, not the port
        rx_s_dest_port = (rx_s_dest_port == 16'd4791) ? 16'd1000 : 16'd4791;
      end
    end
    assert (roce_q.size() == 0 && other_q.size() == 0) else begin
      $display("%s: beats never appeared on their RX output", test_name);
      errors++;
    end
    end_test();
  endtask

  initial begin
    lfsr_state         = lfsr_seed;
    errors             = 0;
    errors_at_start    = 0;
    tests_run          = 0;
    tests_failed       = 0;
    last_cnt           = 0;
    desc_cnt           = 0;
    timed_out          = 1'b0;
    rand_ready         = 1'b0;
    test_name          = "reset";
    rst                = 1'b1;
    start              = 1'b0;
    init_length        = '0;
    init_psn           = '0;
    init_addr          = '0;
    pmtu               = 13'd256;
    desc_ready         = 1'b1;
    m_ready            = 1'b1;
    rx_s_hdr_valid     = 1'b0;
    rx_s_dest_port     = '0;
    rx_s_data          = '0;
    rx_s_keep          = '0;
    rx_s_valid         = 1'b0;
    rx_s_last          = 1'b0;
    rx_roce_hdr_ready  = 1'b1;
    rx_other_hdr_ready = 1'b1;
    rx_roce_ready      = 1'b1;
    rx_other_ready     = 1'b1;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    verify_reset();
    if (!timed_out) begin
      payload_pattern();
    end
    if (!timed_out) begin
      descriptor_sequence();
    end
    if (!timed_out) begin
      message_count();
    end
    if (!timed_out) begin
      back_pressure();
    end
    if (!timed_out) begin
      rx_steering();
    end

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== roce_tx_stream.f ====
design/roce_pkg.sv
design/roce_payload_gen.sv
design/roce_payload_fifo.sv
design/roce_qp_tx_state.sv
design/udp_rx_steer.sv
design/roce_tx_stream.sv
tb/clk_gen.sv
tb/roce_tx_stream_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module roce_tx_stream_tb -f roce_tx_stream.f -o sim \
  && ./obj_dir/sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTBENCH PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
